// File: Makefile
TOP := alu_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

// File: flist.f
+incdir+include
src/alu_pkg.sv
src/fx_arith_unit.sv
src/alu_register_file.sv
src/alu_controller.sv
src/alu_top.sv
tests/alu_sva.sv
tests/alu_tb.sv

// File: include/alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// Q6.10 data path, two's complement
`define ALU_DATA_W   16
`define ALU_FRAC_W   10

// saturation codes
`define ALU_SAT_MAX  16'h7FFF
`define ALU_SAT_MIN  16'h8000

// feedback taps at bits 15, 13, 12 and 10
`define ALU_LFSR_TAPS 16'hB400

`endif

// File: src/alu_controller.sv
`timescale 1ns/1ps

module alu_controller import alu_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset_n,
    input  alu_op_e    i_inst,
    input  logic       i_scan_bit,
    input  logic       i_scan_end,
    input  logic       i_rot_done,
    input  logic       i_shift_done,
    output cal_op_e    o_cal_op,
    output src_sel_e   o_src_a,
    output src_sel_e   o_src_b,
    output logic       o_save_out,
    output logic       o_save_saved,
    output logic       o_save_rot,
    output logic       o_save_lfsr,
    output logic       o_rotate,
    output logic       o_lfsr_step,
    output logic       o_cnt0_clr,
    output logic       o_cnt0_inc,
    output logic       o_cnt1_clr,
    output logic       o_cnt1_inc,
    output logic       o_scan_msb_first,
    output logic       o_busy,
    output logic       o_valid
);

    alu_state_e state_q;
    alu_state_e state_d;

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) state_q <= ST_START;
        else            state_q <= state_d;
    end

    always_comb begin
        state_d          = state_q;
        o_cal_op         = CAL_PASS;
        o_src_a          = SRC_DATA_A;
        o_src_b          = SRC_DATA_B;
        o_save_out       = 1'b0;
        o_save_saved     = 1'b0;
        o_save_rot       = 1'b0;
        o_save_lfsr      = 1'b0;
        o_rotate         = 1'b0;
        o_lfsr_step      = 1'b0;
        o_cnt0_clr       = 1'b0;
        o_cnt0_inc       = 1'b0;
        o_cnt1_clr       = 1'b0;
        o_cnt1_inc       = 1'b0;
        o_scan_msb_first = 1'b0;
        o_busy           = 1'b1;
        o_valid          = 1'b0;

        case (state_q)
            ST_START: state_d = ST_READY;
            ST_READY: begin
                o_busy  = 1'b0;        // one idle cycle, outside sets up inputs
                state_d = ST_WAIT;
            end
            ST_WAIT: state_d = ST_CALC;
            ST_CALC: begin
                state_d = ST_FINISH;
                case (i_inst)
                    OP_ADD: begin
                        o_cal_op   = CAL_ADD;
                        o_save_out = 1'b1;
                    end
                    OP_SUB: begin
                        o_cal_op   = CAL_SUB;
                        o_save_out = 1'b1;
                    end
                    OP_MUL: begin
                        o_cal_op   = CAL_MUL;
                        o_save_out = 1'b1;
                    end
                    OP_MAC: begin
                        o_cal_op     = CAL_MUL;   // hold a*b, add next cycle
                        o_save_saved = 1'b1;
                        state_d      = ST_MAC_ADD;
                    end
                    OP_CLZ: begin
                        o_save_saved = 1'b1;
                        o_cnt0_clr   = 1'b1;
                        state_d      = ST_CLZ;
                    end
                    OP_LRCW: begin
                        o_save_saved = 1'b1;      // a is scanned for its ones
                        o_cnt0_clr   = 1'b1;
                        o_cnt1_clr   = 1'b1;
                        state_d      = ST_SAVE_B;
                    end
                    OP_LFSR: begin
                        o_src_a      = SRC_DATA_B;   // step count
                        o_save_saved = 1'b1;
                        o_cnt0_clr   = 1'b1;
                        state_d      = ST_SAVE_A;
                    end
                    default: begin
                        // a - a, so unused opcodes load zero
                        o_cal_op   = CAL_SUB;
                        o_src_b    = SRC_DATA_A;
                        o_save_out = 1'b1;
                    end
                endcase
            end
            ST_MAC_ADD: begin
                o_cal_op   = CAL_ADD;
                o_src_a    = SRC_SAVED;
                o_src_b    = SRC_RESULT;
                o_save_out = 1'b1;
                state_d    = ST_FINISH;
            end
            ST_CLZ: begin
                o_scan_msb_first = 1'b1;
                if (!i_scan_end && !i_scan_bit) begin
                    o_cnt0_inc = 1'b1;
                end else begin
                    o_src_a    = SRC_COUNT;
                    o_save_out = 1'b1;
                    state_d    = ST_FINISH;
                end
            end
            ST_SAVE_B: begin
                o_src_a    = SRC_DATA_B;
                o_save_rot = 1'b1;
                state_d    = ST_CPOP;
            end
            ST_CPOP: begin
                if (!i_scan_end) begin
                    o_cnt0_inc = 1'b1;
                    o_cnt1_inc = i_scan_bit;    // counter 1 holds the popcount
                end else begin
                    o_cnt0_clr = 1'b1;
                    state_d    = ST_ROTATE;
                end
            end
            ST_ROTATE: begin
                if (!i_rot_done) begin
                    o_rotate   = 1'b1;
                    o_cnt0_inc = 1'b1;
                end else begin
                    o_src_a    = SRC_ROT;
                    o_save_out = 1'b1;
                    state_d    = ST_FINISH;
                end
            end
            ST_SAVE_A: begin
                o_save_lfsr = 1'b1;    // seed
                state_d     = ST_LFSR;
            end
            ST_LFSR: begin
                if (!i_shift_done) begin
                    o_lfsr_step = 1'b1;
                    o_cnt0_inc  = 1'b1;
                end else begin
                    o_src_a    = SRC_LFSR;
                    o_save_out = 1'b1;
                    state_d    = ST_FINISH;
                end
            end
            ST_FINISH: begin
                o_valid = 1'b1;
                state_d = ST_READY;
            end
            default: state_d = ST_START;
        endcase
    end

endmodule

// File: src/alu_pkg.sv
package alu_pkg;

    // opcodes 4 and 8..15 are not listed and return zero
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_MUL  = 4'd2,
        OP_MAC  = 4'd3,
        OP_CLZ  = 4'd5,
        OP_LRCW = 4'd6,
        OP_LFSR = 4'd7
    } alu_op_e;

    typedef enum logic [3:0] {
        ST_START,
        ST_READY,
        ST_WAIT,
        ST_CALC,
        ST_MAC_ADD,
        ST_CLZ,
        ST_SAVE_B,
        ST_CPOP,
        ST_ROTATE,
        ST_SAVE_A,
        ST_LFSR,
        ST_FINISH
    } alu_state_e;

    typedef enum logic [1:0] {CAL_ADD, CAL_SUB, CAL_MUL, CAL_PASS} cal_op_e;

    typedef enum logic [2:0] {
        SRC_DATA_A, SRC_DATA_B, SRC_SAVED, SRC_RESULT, SRC_ROT, SRC_LFSR, SRC_COUNT
    } src_sel_e;

endpackage

// File: src/alu_register_file.sv
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_register_file import alu_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  logic [`ALU_DATA_W-1:0] i_data_a,
    input  logic [`ALU_DATA_W-1:0] i_data_b,
    input  logic [`ALU_DATA_W-1:0] i_result,
    input  src_sel_e               i_src_a,
    input  src_sel_e               i_src_b,
    input  logic                   i_save_out,
    input  logic                   i_save_saved,
    input  logic                   i_save_rot,
    input  logic                   i_save_lfsr,
    input  logic                   i_rotate,
    input  logic                   i_lfsr_step,
    input  logic                   i_cnt0_clr,
    input  logic                   i_cnt0_inc,
    input  logic                   i_cnt1_clr,
    input  logic                   i_cnt1_inc,
    input  logic                   i_scan_msb_first,
    output logic [`ALU_DATA_W-1:0] o_op_a,
    output logic [`ALU_DATA_W-1:0] o_op_b,
    output logic [`ALU_DATA_W-1:0] o_data,
    output logic                   o_scan_bit,
    output logic                   o_scan_end,
    output logic                   o_rot_done,
    output logic                   o_shift_done
);

    logic [`ALU_DATA_W-1:0] result_q;
    logic [`ALU_DATA_W-1:0] saved_q;     // product for MAC, scanned word otherwise
    logic [`ALU_DATA_W-1:0] rot_q;
    logic [`ALU_DATA_W-1:0] lfsr_q;
    logic [`ALU_DATA_W-1:0] cnt0_q;
    logic [`ALU_DATA_W-1:0] cnt1_q;
    logic [3:0]             scan_idx;

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            result_q <= '0;
            cnt0_q   <= '0;
            cnt1_q   <= '0;
        end else begin
            if (i_save_out) result_q <= i_result;
            if (i_cnt0_clr)      cnt0_q <= '0;
            else if (i_cnt0_inc) cnt0_q <= cnt0_q + 1'b1;
            if (i_cnt1_clr)      cnt1_q <= '0;
            else if (i_cnt1_inc) cnt1_q <= cnt1_q + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_save_saved) saved_q <= i_result;
        if (i_save_rot)    rot_q <= i_result;
        else if (i_rotate) rot_q <= {rot_q[`ALU_DATA_W-2:0], ~rot_q[`ALU_DATA_W-1]};
        if (i_save_lfsr)      lfsr_q <= i_result;
        else if (i_lfsr_step) lfsr_q <= {lfsr_q[`ALU_DATA_W-2:0], ^(lfsr_q & `ALU_LFSR_TAPS)};
    end

    function automatic logic [`ALU_DATA_W-1:0] pick_src(src_sel_e sel);
        case (sel)
            SRC_DATA_A: return i_data_a;
            SRC_DATA_B: return i_data_b;
            SRC_SAVED:  return saved_q;
            SRC_RESULT: return result_q;
            SRC_ROT:    return rot_q;
            SRC_LFSR:   return lfsr_q;
            SRC_COUNT:  return cnt0_q;
            default:    return i_data_a;
        endcase
    endfunction

    assign o_op_a = pick_src(i_src_a);
    assign o_op_b = pick_src(i_src_b);
    assign o_data = result_q;

    // CLZ walks down from bit 15, popcount walks up from bit 0
    assign scan_idx     = i_scan_msb_first ? ~cnt0_q[3:0] : cnt0_q[3:0];
    assign o_scan_bit   = saved_q[scan_idx];
    assign o_scan_end   = cnt0_q >= `ALU_DATA_W'(`ALU_DATA_W);
    assign o_rot_done   = cnt0_q >= cnt1_q;
    assign o_shift_done = cnt0_q >= saved_q;     // unsigned step count

endmodule

// File: src/alu_top.sv
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_top import alu_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  logic [`ALU_DATA_W-1:0] i_data_a,
    input  logic [`ALU_DATA_W-1:0] i_data_b,
    input  alu_op_e                i_inst,
    output logic                   o_valid,
    output logic                   o_busy,
    output logic [`ALU_DATA_W-1:0] o_data
);

    cal_op_e                cal_op;
    src_sel_e               src_a;
    src_sel_e               src_b;
    logic [`ALU_DATA_W-1:0] op_a;
    logic [`ALU_DATA_W-1:0] op_b;
    logic [`ALU_DATA_W-1:0] result;

    // register strobes from the FSM
    logic save_out, save_saved, save_rot, save_lfsr;
    logic rotate, lfsr_step;
    logic cnt0_clr, cnt0_inc, cnt1_clr, cnt1_inc, scan_msb_first;

    // loop status back to the FSM
    logic scan_bit, scan_end, rot_done, shift_done;

    alu_controller u_ctrl (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_inst(i_inst),
        .i_scan_bit(scan_bit), .i_scan_end(scan_end),
        .i_rot_done(rot_done), .i_shift_done(shift_done),
        .o_cal_op(cal_op), .o_src_a(src_a), .o_src_b(src_b),
        .o_save_out(save_out), .o_save_saved(save_saved),
        .o_save_rot(save_rot), .o_save_lfsr(save_lfsr),
        .o_rotate(rotate), .o_lfsr_step(lfsr_step),
        .o_cnt0_clr(cnt0_clr), .o_cnt0_inc(cnt0_inc),
        .o_cnt1_clr(cnt1_clr), .o_cnt1_inc(cnt1_inc),
        .o_scan_msb_first(scan_msb_first),
        .o_busy(o_busy), .o_valid(o_valid)
    );

    alu_register_file u_regs (
        .i_clk(i_clk), .i_reset_n(i_reset_n),
        .i_data_a(i_data_a), .i_data_b(i_data_b), .i_result(result),
        .i_src_a(src_a), .i_src_b(src_b),
        .i_save_out(save_out), .i_save_saved(save_saved),
        .i_save_rot(save_rot), .i_save_lfsr(save_lfsr),
        .i_rotate(rotate), .i_lfsr_step(lfsr_step),
        .i_cnt0_clr(cnt0_clr), .i_cnt0_inc(cnt0_inc),
        .i_cnt1_clr(cnt1_clr), .i_cnt1_inc(cnt1_inc),
        .i_scan_msb_first(scan_msb_first),
        .o_op_a(op_a), .o_op_b(op_b), .o_data(o_data),
        .o_scan_bit(scan_bit), .o_scan_end(scan_end),
        .o_rot_done(rot_done), .o_shift_done(shift_done)
    );

    fx_arith_unit u_arith (
        .i_cal_op(cal_op), .i_op_a(op_a), .i_op_b(op_b), .o_result(result)
    );

endmodule

// File: src/fx_arith_unit.sv
`timescale 1ns/1ps
`include "alu_consts.svh"

module fx_arith_unit import alu_pkg::*; (
    input  cal_op_e                       i_cal_op,
    input  logic signed [`ALU_DATA_W-1:0] i_op_a,
    input  logic signed [`ALU_DATA_W-1:0] i_op_b,
    output logic        [`ALU_DATA_W-1:0] o_result
);

    localparam int MSB     = `ALU_DATA_W - 1;
    localparam int PROD_W  = 2 * `ALU_DATA_W;
    localparam int INT_W   = PROD_W - 2 * `ALU_FRAC_W;    // integer bits of the product
    localparam int INT_MAX = 2 ** (`ALU_DATA_W - `ALU_FRAC_W - 1) - 1;
    localparam int INT_MIN = -(INT_MAX + 1);

    logic signed [`ALU_DATA_W-1:0] sum;
    logic signed [`ALU_DATA_W-1:0] diff;
    logic signed [PROD_W-1:0]      product;
    logic signed [INT_W-1:0]       prod_int;
    logic        [`ALU_DATA_W:0]   prod_rnd;    // extra bit catches the round carry

    assign sum      = i_op_a + i_op_b;
    assign diff     = i_op_a - i_op_b;
    assign product  = i_op_a * i_op_b;
    assign prod_int = product[PROD_W-1 -: INT_W];

    // round half up on the first dropped fraction bit
    assign prod_rnd = {product[MSB+`ALU_FRAC_W], product[MSB+`ALU_FRAC_W:`ALU_FRAC_W]}
                    + {{`ALU_DATA_W{1'b0}}, product[`ALU_FRAC_W-1]};

    always_comb begin
        o_result = i_op_a;
        case (i_cal_op)
            CAL_ADD: begin
                o_result = sum;
                if (!i_op_a[MSB] && !i_op_b[MSB] && sum[MSB])
                    o_result = `ALU_SAT_MAX;    // pos + pos wrapped
                else if (i_op_a[MSB] && i_op_b[MSB] && !sum[MSB])
                    o_result = `ALU_SAT_MIN;
            end
            CAL_SUB: begin
                o_result = diff;
                if (!i_op_a[MSB] && i_op_b[MSB] && diff[MSB])
                    o_result = `ALU_SAT_MAX;
                else if (i_op_a[MSB] && !i_op_b[MSB] && !diff[MSB])
                    o_result = `ALU_SAT_MIN;
            end
            CAL_MUL: begin
                if (prod_int > INT_MAX)
                    o_result = `ALU_SAT_MAX;
                else if (prod_int < INT_MIN)
                    o_result = `ALU_SAT_MIN;
                else if (prod_rnd[`ALU_DATA_W] != prod_rnd[MSB])
                    o_result = `ALU_SAT_MAX;    // 31.999.. rounded up past the top
                else
                    o_result = prod_rnd[MSB:0];
            end
            CAL_PASS: o_result = i_op_a;
            default:  o_result = i_op_a;
        endcase
    end

endmodule

// File: tests/alu_sva.sv
`timescale 1ns/1ps

module alu_sva (
    input logic i_clk,
    input logic i_reset_n,
    input logic i_busy,
    input logic i_valid
);

    // result strobe is a single cycle
    a_valid_pulse: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_valid |=> !i_valid)
        else $error("o_valid stayed high for more than one cycle");

    a_valid_not_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(i_valid && !i_busy))
        else $error("o_valid seen while o_busy was low");

    // back to ready right after each result
    a_ready_after_valid: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_valid |=> !i_busy)
        else $error("o_busy not low in the cycle after o_valid");

endmodule

bind alu_top alu_sva u_sva (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_busy(o_busy), .i_valid(o_valid)
);

// File: tests/alu_tb.sv
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_tb import alu_pkg::*; ();

    localparam int CLK_PERIOD  = 100;
    localparam int NUM_TESTS   = 32;
    localparam int WATCHDOG_NS = NUM_TESTS * 80 * CLK_PERIOD;

    logic                   clk = 1'b0;
    logic                   reset_n;
    logic [`ALU_DATA_W-1:0] data_a;
    logic [`ALU_DATA_W-1:0] data_b;
    alu_op_e                inst;
    logic                   valid;
    logic                   busy;
    logic [`ALU_DATA_W-1:0] data_out;

    // stimulus table of opcode, a, b, expected result and latency (0 when data dependent)
    logic [3:0]             tbl_op  [NUM_TESTS];
    logic [`ALU_DATA_W-1:0] tbl_a   [NUM_TESTS];
    logic [`ALU_DATA_W-1:0] tbl_b   [NUM_TESTS];
    logic [`ALU_DATA_W-1:0] tbl_exp [NUM_TESTS];
    int                     tbl_lat [NUM_TESTS];
    int                     n_entries = 0;
    int                     errors = 0;

    alu_top uut (
        .i_clk(clk), .i_reset_n(reset_n), .i_data_a(data_a), .i_data_b(data_b),
        .i_inst(inst), .o_valid(valid), .o_busy(busy), .o_data(data_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] clz_ref(input logic [15:0] a);
        int n;
        n = 0;
        while (n < 16 && !a[15 - n]) n++;
        return 16'(n);
    endfunction

    // b rotated left once per one bit of a with the wrapped bit inverted
    function automatic logic [15:0] lrcw_ref(input logic [15:0] a, input logic [15:0] b);
        logic [15:0] r;
        r = b;
        for (int i = 0; i < $countones(a); i++)
            r = {r[14:0], ~r[15]};
        return r;
    endfunction

    function automatic logic [15:0] lfsr_ref(input logic [15:0] a, input logic [15:0] b);
        logic [15:0] r;
        r = a;
        for (int i = 0; i < int'(b); i++)
            r = {r[14:0], r[15] ^ r[13] ^ r[12] ^ r[10]};
        return r;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED at %0d ns: %s, got 0x%0h expected 0x%0h", $time, what, got,
                     expected);
            errors++;
        end
    endtask

    task automatic add_entry(input logic [3:0] op, input logic [15:0] a, input logic [15:0] b,
                             input logic [15:0] expected, input int lat);
        tbl_op[n_entries]  = op;
        tbl_a[n_entries]   = a;
        tbl_b[n_entries]   = b;
        tbl_exp[n_entries] = expected;
        tbl_lat[n_entries] = lat;
        n_entries++;
    endtask

    task automatic build_table();
        logic [15:0] ra;
        logic [15:0] rb;
        add_entry(OP_ADD, 16'h0400, 16'h0C00, 16'h1000, 3);   // 1 + 3
        add_entry(OP_ADD, 16'h7C00, 16'h0800, 16'h7FFF, 3);
        add_entry(OP_SUB, 16'h0800, 16'h0C00, 16'hFC00, 3);   // 2 - 3
        add_entry(OP_SUB, 16'h8400, 16'h0800, 16'h8000, 3);
        add_entry(OP_MUL, 16'h0600, 16'h0800, 16'h0C00, 3);   // 1.5 * 2.0
        add_entry(OP_MUL, 16'h0001, 16'h0200, 16'h0001, 3);   // half lsb rounds up
        add_entry(OP_MUL, 16'h5000, 16'h0C00, 16'h7FFF, 3);   // 20 * 3
        add_entry(OP_MUL, 16'hF800, 16'h0600, 16'hF400, 3);   // -2.0 * 1.5
        add_entry(OP_ADD, 16'h0400, 16'h0400, 16'h0800, 3);   // MAC base 2.0
        add_entry(OP_MAC, 16'h0600, 16'h0800, 16'h1400, 4);   // 3 + 2
        add_entry(OP_MAC, 16'h1000, 16'h1000, 16'h5400, 4);   // 16 + 5
        add_entry(OP_MAC, 16'h1000, 16'h1000, 16'h7FFF, 4);   // 16 + 21 saturates
        add_entry(OP_CLZ, 16'h0000, 16'h0000, 16'd16, 0);
        add_entry(OP_CLZ, 16'h8000, 16'h0000, 16'd0, 0);
        add_entry(OP_CLZ, 16'h0001, 16'h0000, 16'd15, 0);
        add_entry(OP_LRCW, 16'h0000, 16'h1234, 16'h1234, 0); // no ones so b is unchanged
        add_entry(OP_LFSR, 16'hACE1, 16'h0000, 16'hACE1, 0); // zero steps
        add_entry(4'd4, 16'h1234, 16'h5678, 16'h0000, 3);
        add_entry(4'd8, 16'h1234, 16'h5678, 16'h0000, 3);
        add_entry(4'd15, 16'hFFFF, 16'h8001, 16'h0000, 3);
        for (int i = 0; i < 4; i++) begin
            ra = 16'($urandom) >> ($urandom % 16);   // spread the zero count
            add_entry(OP_CLZ, ra, 16'h0000, clz_ref(ra), 0);
        end
        for (int i = 0; i < 4; i++) begin
            ra = 16'($urandom);
            rb = 16'($urandom);
            add_entry(OP_LRCW, ra, rb, lrcw_ref(ra, rb), 0);
        end
        for (int i = 0; i < 4; i++) begin
            ra = 16'($urandom);
            rb = 16'($urandom % 21);
            add_entry(OP_LFSR, ra, rb, lfsr_ref(ra, rb), 0);
        end
    endtask

    // entered at the negedge of a ready cycle and returns at the next one
    task automatic run_test(input int t);
        int          lat;
        int          errs_before;
        logic [15:0] got;
        errs_before = errors;
        @(posedge clk);
        #1;
        inst   = alu_op_e'(tbl_op[t]);
        data_a = tbl_a[t];
        data_b = tbl_b[t];
        lat    = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!valid);
        got = data_out;
        compare_value($sformatf("test %0d result", t), 32'(got), 32'(tbl_exp[t]));
        compare_value($sformatf("test %0d busy with valid", t), 32'(busy), 32'd1);
        if (tbl_lat[t] != 0)
            compare_value($sformatf("test %0d latency", t), 32'(lat), 32'(tbl_lat[t]));
        @(negedge clk);
        compare_value($sformatf("test %0d ready after valid", t), 32'(busy), 32'd0);
        compare_value($sformatf("test %0d valid width", t), 32'(valid), 32'd0);
        $display("test %2d: op %2d a=%04h b=%04h -> %04h in %0d cycles, %s", t, tbl_op[t],
                 tbl_a[t], tbl_b[t], got, lat, (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        reset_n = 1'b0;
        data_a  = '0;
        data_b  = '0;
        inst    = OP_ADD;
        void'($urandom(6480));
        build_table();
        repeat (7) @(posedge clk);
        @(negedge clk);
        compare_value("o_data in reset", 32'(data_out), 32'd0);
        compare_value("o_valid in reset", 32'(valid), 32'd0);
        @(posedge clk);
        #1 reset_n = 1'b1;
        do @(negedge clk); while (busy);   // first ready cycle
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);
        $display("%0d tests run, %0d checks failed", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the ALU did not finish all tests within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
